// ==== tb.f ====
src/mbox_map_pkg.sv
src/mbox_link_pkg.sv
src/req_fifo.sv
src/ss_pair_collector.sv
src/mbox_regs.sv
src/mbox_dispatch_fsm.sv
src/axi_mbox_ctrl.sv
testbench/tb_clock_gen.sv
testbench/tb_axi_mbox_ctrl.sv

// ==== Bender.yml ====
package:
  name: axi_mbox_ctrl

sources:
  - src/mbox_map_pkg.sv
  - src/mbox_link_pkg.sv
  - src/req_fifo.sv
  - src/ss_pair_collector.sv
  - src/mbox_regs.sv
  - src/mbox_dispatch_fsm.sv
  - src/axi_mbox_ctrl.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_axi_mbox_ctrl.sv

// ==== testbench/tb_axi_mbox_ctrl.sv ====
/*
 * testbench for the AXI mailbox controller
 * table of local, remote and burst operations checked against a register model
 */
`timescale 1ns/100ps
`default_nettype none

module tb_axi_mbox_ctrl;

	// row kinds
	localparam logic [1:0] k_lwr = 2'd0;
	localparam logic [1:0] k_lrd = 2'd1;
	localparam logic [1:0] k_rpair = 2'd2;
	localparam logic [1:0] k_burst = 2'd3;
	// cycles per wait, reads per poll
	localparam int wait_limit = 200;
	localparam int poll_limit = 16;

	// one table row, exp_val only used when use_model is low
	typedef struct packed {
		logic [1:0] kind;
		logic [14:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
		logic [31:0] exp_val;
		logic use_model;
	} op_row_t;

	logic axi_aclk;
	logic axi_aresetn;
	logic bk_ls_wstart;
	logic [14:0] bk_ls_waddr;
	logic [31:0] bk_ls_wdata;
	logic [3:0] bk_ls_wstrb;
	logic bk_ls_rstart;
	logic [14:0] bk_ls_raddr;
	logic [31:0] bk_ls_rdata;
	logic bk_ls_rdone;
	logic [31:0] bk_ss_data;
	logic [1:0] bk_ss_user;
	logic bk_ss_valid;
	logic bk_ss_ready;
	logic bk_sm_start;
	logic [31:0] bk_sm_data;
	logic [1:0] bk_sm_user;
	logic axi_interrupt;

	op_row_t ops[$];
	// register model
	logic [31:0] mb_model [8];
	logic en_model;
	logic st_model;
	int int_expect;
	int int_count = 0;
	logic saw_stall;

	tb_clock_gen u_clk (.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn));

	axi_mbox_ctrl DUT (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
		.bk_ls_wstart(bk_ls_wstart), .bk_ls_waddr(bk_ls_waddr),
		.bk_ls_wdata(bk_ls_wdata), .bk_ls_wstrb(bk_ls_wstrb),
		.bk_ls_rstart(bk_ls_rstart), .bk_ls_raddr(bk_ls_raddr),
		.bk_ls_rdata(bk_ls_rdata), .bk_ls_rdone(bk_ls_rdone),
		.bk_ss_data(bk_ss_data), .bk_ss_user(bk_ss_user),
		.bk_ss_valid(bk_ss_valid), .bk_ss_ready(bk_ss_ready),
		.bk_sm_start(bk_sm_start), .bk_sm_data(bk_sm_data), .bk_sm_user(bk_sm_user),
		.axi_interrupt(axi_interrupt)
	);

	// cycles with the interrupt high, sampled on the rising edge
	always @(posedge axi_aclk) begin
		if (axi_aresetn && axi_interrupt) begin
			int_count <= int_count + 1;
		end
	end

	// --------------------------------------------------
	// failure reporting
	// --------------------------------------------------
	task automatic fail_stop();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERR at %0t ns: %s, got 0x%08h, expected 0x%08h",
				$time, what, actual, expected);
			fail_stop();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		fail_stop();
	endtask

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic logic in_mailbox(input logic [14:0] addr);
		return (addr >= 15'h2000) && (addr <= 15'h201F);
	endfunction

	function automatic logic in_control(input logic [14:0] addr);
		return (addr >= 15'h2100) && (addr <= 15'h2107);
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
			input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = data[8*b +: 8];
			end
		end
		return res;
	endfunction

	// control regs take lane 0 only, status is write one to clear
	function automatic void apply_local_write(input logic [14:0] addr,
			input logic [31:0] data, input logic [3:0] strb);
		if (in_mailbox(addr)) begin
			mb_model[addr[2:0]] = merge_bytes(mb_model[addr[2:0]], data, strb);
		end else if (in_control(addr) && strb[0]) begin
			if (!addr[0]) begin
				en_model = data[0];
			end else if (data[0]) begin
				st_model = 1'b0;
			end
		end
	endfunction

	// returns high when a pulse is due
	function automatic logic apply_remote_write(input logic [14:0] addr,
			input logic [31:0] data, input logic [3:0] strb);
		if (!in_mailbox(addr)) begin
			return 1'b0;
		end
		mb_model[addr[2:0]] = merge_bytes(mb_model[addr[2:0]], data, strb);
		if (en_model) begin
			st_model = 1'b1;
			int_expect++;
		end
		return en_model;
	endfunction

	// holes inside the block read all ones
	function automatic logic [31:0] expected_read(input logic [14:0] addr);
		if (in_mailbox(addr)) begin
			return mb_model[addr[2:0]];
		end
		if (in_control(addr)) begin
			return {31'b0, addr[0] ? st_model : en_model};
		end
		return 32'hFFFF_FFFF;
	endfunction

	// --------------------------------------------------
	// local side
	// --------------------------------------------------
	task automatic local_write(input logic [14:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		int waited;
		apply_local_write(addr, data, strb);
		@(negedge axi_aclk);
		bk_ls_wstart = 1'b1;
		bk_ls_waddr = addr;
		bk_ls_wdata = data;
		bk_ls_wstrb = strb;
		@(negedge axi_aclk);
		bk_ls_wstart = 1'b0;
		if (in_mailbox(addr)) begin
			waited = 0;
			while (!bk_sm_start) begin
				@(negedge axi_aclk);
				waited++;
				if (waited > wait_limit) report_timeout("the mirror beats");
			end
			// header beat, then data beat, then quiet
			check_value(bk_sm_user, 2'b01, "mirror header tag");
			check_value(bk_sm_data, {strb, 13'h0, addr}, "mirror header");
			@(negedge axi_aclk);
			check_value(bk_sm_start, 1'b1, "mirror second beat start");
			check_value(bk_sm_user, 2'b01, "mirror data tag");
			check_value(bk_sm_data, data, "mirror data");
			@(negedge axi_aclk);
			check_value(bk_sm_start, 1'b0, "mirror start after two beats");
		end
	endtask

	task automatic local_read(input logic [14:0] addr, output logic [31:0] data);
		int waited;
		@(negedge axi_aclk);
		bk_ls_rstart = 1'b1;
		bk_ls_raddr = addr;
		@(negedge axi_aclk);
		bk_ls_rstart = 1'b0;
		waited = 0;
		while (!bk_ls_rdone) begin
			@(negedge axi_aclk);
			waited++;
			if (waited > wait_limit) report_timeout("the read reply");
		end
		data = bk_ls_rdata;
		@(negedge axi_aclk);
		check_value(bk_ls_rdone, 1'b0, "rdone after one cycle");
	endtask

	task automatic read_expect(input logic [14:0] addr, input logic [31:0] expected);
		logic [31:0] got;
		local_read(addr, got);
		check_value(got, expected, $sformatf("read of 0x%04h", addr));
	endtask

	// --------------------------------------------------
	// stream side
	// --------------------------------------------------
	// beat goes in at the next rising edge once ready is seen
	task automatic send_beat(input logic [31:0] data, input logic [1:0] tag);
		int waited;
		@(negedge axi_aclk);
		bk_ss_data = data;
		bk_ss_user = tag;
		bk_ss_valid = 1'b1;
		waited = 0;
		while (!bk_ss_ready) begin
			saw_stall = 1'b1;
			@(negedge axi_aclk);
			waited++;
			if (waited > wait_limit) report_timeout("stream ready");
		end
	endtask

	task automatic send_pair(input logic [14:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		send_beat({strb, 13'h0, addr}, 2'b01);
		send_beat(data, 2'b01);
	endtask

	task automatic release_stream();
		@(negedge axi_aclk);
		bk_ss_valid = 1'b0;
	endtask

	task automatic wait_interrupts();
		int waited;
		waited = 0;
		while (int_count < int_expect) begin
			@(negedge axi_aclk);
			waited++;
			if (waited > wait_limit) report_timeout("the interrupt pulse");
		end
		// a wider pulse would count again here
		repeat (2) @(negedge axi_aclk);
		check_value(int_count, int_expect, "interrupt pulse count");
	endtask

	task automatic remote_write(input logic [14:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] got;
		int polls;
		send_pair(addr, data, strb);
		release_stream();
		if (apply_remote_write(addr, data, strb)) begin
			wait_interrupts();
		end else begin
			// no pulse to wait on, poll until the word lands
			polls = 0;
			got = ~expected_read(addr);
			while (got !== expected_read(addr)) begin
				if (polls == poll_limit) report_timeout("the remote write to land");
				local_read(addr, got);
				polls++;
			end
			check_value(int_count, int_expect, "interrupt pulse count");
		end
	endtask

	// stream floods words 0..3 while local traffic works on 4..7
	task automatic run_burst();
		saw_stall = 1'b0;
		fork
			begin : stream_side
				logic [14:0] a;
				logic [31:0] d;
				// stray tag, dropped by the collector
				send_beat(32'hDEAD_BEEF, 2'b10);
				for (int i = 0; i < 14; i++) begin
					a = 15'h2000 + 15'(i % 4);
					d = $urandom;
					void'(apply_remote_write(a, d, 4'hF));
					send_pair(a, d, 4'hF);
				end
				release_stream();
			end
			begin : local_side
				logic [14:0] a;
				for (int i = 0; i < 4; i++) begin
					a = 15'h2004 + 15'(i);
					local_write(a, $urandom, 4'hF);
					read_expect(a, expected_read(a));
				end
			end
		join
		wait_interrupts();
		check_value(saw_stall, 1'b1, "stream ready drop during the burst");
	endtask

	// --------------------------------------------------
	// operation table
	// --------------------------------------------------
	function automatic void add_row(input logic [1:0] kind, input logic [14:0] addr,
			input logic [31:0] data, input logic [3:0] strb, input logic [31:0] exp_val,
			input logic use_model);
		ops.push_back('{kind, addr, data, strb, exp_val, use_model});
	endfunction

	function automatic void build_ops();
		// zero after reset
		for (int i = 0; i < 8; i++) begin
			add_row(k_lrd, 15'h2000 + 15'(i), '0, '0, '0, 1'b0);
		end
		// byte lanes under strobe
		add_row(k_lwr, 15'h2003, $urandom, 4'b0101, '0, 1'b0);
		add_row(k_lrd, 15'h2003, '0, '0, '0, 1'b1);
		add_row(k_lwr, 15'h2003, $urandom, 4'b1010, '0, 1'b0);
		add_row(k_lrd, 15'h2003, '0, '0, '0, 1'b1);
		add_row(k_lwr, 15'h2000, $urandom, 4'hF, '0, 1'b0);
		// 0x2019 aliases word 1
		add_row(k_lwr, 15'h2019, $urandom, 4'hF, '0, 1'b0);
		add_row(k_lwr, 15'h2007, $urandom, 4'b1000, '0, 1'b0);
		// hole in the block
		add_row(k_lrd, 15'h2050, '0, '0, 32'hFFFF_FFFF, 1'b0);
		add_row(k_lwr, 15'h2050, $urandom, 4'hF, '0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			add_row(k_lrd, 15'h2000 + 15'(i), '0, '0, '0, 1'b1);
		end
		// enable keeps bit 0, lane 0 strobe needed
		add_row(k_lwr, 15'h2100, 32'hFFFF_FFFF, 4'hF, '0, 1'b0);
		add_row(k_lrd, 15'h2100, '0, '0, 32'h1, 1'b0);
		add_row(k_lwr, 15'h2100, 32'hFFFF_FFFE, 4'hF, '0, 1'b0);
		add_row(k_lrd, 15'h2100, '0, '0, 32'h0, 1'b0);
		add_row(k_lwr, 15'h2100, 32'h1, 4'hE, '0, 1'b0);
		add_row(k_lrd, 15'h2100, '0, '0, 32'h0, 1'b0);
		// remote pair, enable set
		add_row(k_lwr, 15'h2100, 32'h1, 4'h1, '0, 1'b0);
		add_row(k_rpair, 15'h2005, $urandom, 4'hF, '0, 1'b0);
		add_row(k_lrd, 15'h2101, '0, '0, 32'h1, 1'b0);
		add_row(k_lrd, 15'h2005, '0, '0, '0, 1'b1);
		// zero leaves the status, one clears it
		add_row(k_lwr, 15'h2101, 32'h0, 4'h1, '0, 1'b0);
		add_row(k_lrd, 15'h2101, '0, '0, 32'h1, 1'b0);
		add_row(k_lwr, 15'h2101, 32'h1, 4'h1, '0, 1'b0);
		add_row(k_lrd, 15'h2101, '0, '0, 32'h0, 1'b0);
		// remote pair, enable clear
		add_row(k_lwr, 15'h2100, 32'h0, 4'h1, '0, 1'b0);
		add_row(k_rpair, 15'h2006, $urandom, 4'b0011, '0, 1'b0);
		add_row(k_lrd, 15'h2101, '0, '0, 32'h0, 1'b0);
		add_row(k_lrd, 15'h2006, '0, '0, '0, 1'b1);
		// flood with interleaved local traffic
		add_row(k_lwr, 15'h2100, 32'h1, 4'h1, '0, 1'b0);
		add_row(k_burst, '0, '0, '0, '0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			add_row(k_lrd, 15'h2000 + 15'(i), '0, '0, '0, 1'b1);
		end
		add_row(k_lrd, 15'h2101, '0, '0, 32'h1, 1'b0);
	endfunction

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		op_row_t row;
		int waited;
		void'($urandom(33737));
		bk_ls_wstart = 1'b0;
		bk_ls_waddr = '0;
		bk_ls_wdata = '0;
		bk_ls_wstrb = '0;
		bk_ls_rstart = 1'b0;
		bk_ls_raddr = '0;
		bk_ss_data = '0;
		bk_ss_user = '0;
		bk_ss_valid = 1'b0;
		for (int i = 0; i < 8; i++) begin
			mb_model[i] = '0;
		end
		en_model = 1'b0;
		st_model = 1'b0;
		int_expect = 0;
		saw_stall = 1'b0;
		build_ops();

		waited = 0;
		while (axi_aresetn !== 1'b1) begin
			@(negedge axi_aclk);
			waited++;
			if (waited > 100) report_timeout("reset release");
		end
		// idle outputs
		check_value(bk_ls_rdone, 1'b0, "rdone after reset");
		check_value(bk_sm_start, 1'b0, "sm_start after reset");
		check_value(axi_interrupt, 1'b0, "interrupt after reset");
		check_value(bk_ss_ready, 1'b1, "ss_ready after reset");

		foreach (ops[i]) begin
			row = ops[i];
			case (row.kind)
				k_lwr: local_write(row.addr, row.data, row.strb);
				k_lrd: read_expect(row.addr,
					row.use_model ? expected_read(row.addr) : row.exp_val);
				k_rpair: remote_write(row.addr, row.data, row.strb);
				default: run_burst();
			endcase
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
/*
 * testbench clock and reset
 * 40 ns clock, active low reset held for 16 cycles
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic axi_aclk,
	output logic axi_aresetn
);

	// 25 MHz
	initial begin
		axi_aclk = 1'b0;
		forever #20 axi_aclk = ~axi_aclk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		axi_aresetn = 1'b0;
		repeat (16) @(posedge axi_aclk);
		@(negedge axi_aclk);
		axi_aresetn = 1'b1;
	end

endmodule

`default_nettype wire

// ==== src/axi_mbox_ctrl.sv ====
/*
 * AXI mailbox controller
 * local and stream request queues feeding one dispatcher and the register file
 */
`timescale 1ns/100ps
`default_nettype none

module axi_mbox_ctrl (
	input  logic axi_aclk,
	input  logic axi_aresetn,
	// local AXI-Lite slave requests
	input  logic bk_ls_wstart,
	input  mbox_map_pkg::local_addr_t bk_ls_waddr,
	input  mbox_link_pkg::word_t bk_ls_wdata,
	input  mbox_link_pkg::strb_t bk_ls_wstrb,
	input  logic bk_ls_rstart,
	input  mbox_map_pkg::local_addr_t bk_ls_raddr,
	output mbox_link_pkg::word_t bk_ls_rdata,
	output logic bk_ls_rdone,
	// stream slave
	input  mbox_link_pkg::word_t bk_ss_data,
	input  mbox_link_pkg::tag_t bk_ss_user,
	input  logic bk_ss_valid,
	output logic bk_ss_ready,
	// stream master
	output logic bk_sm_start,
	output mbox_link_pkg::word_t bk_sm_data,
	output mbox_link_pkg::tag_t bk_sm_user,
	output logic axi_interrupt
);
	import mbox_link_pkg::*;

	ls_entry_t ls_in;
	ls_entry_t ls_head;
	logic ls_push;
	logic ls_full;
	logic ls_pop;
	logic ls_avail;

	ss_beat_t ss_in;
	ss_beat_t ss_head;
	logic ss_push;
	logic ss_full;
	logic ss_pop;
	logic ss_avail;

	logic pair_valid;
	strb_t pair_strb;
	logic [remote_addr_w-1:0] pair_addr;
	word_t pair_data;
	logic pair_take;

	logic mb_we;
	logic [mbox_map_pkg::mb_index_w-1:0] mb_idx;
	logic [mbox_map_pkg::mb_index_w-1:0] mb_re_idx;
	strb_t wr_strb;
	word_t wr_data;
	logic aa_we;
	logic [mbox_map_pkg::aa_index_w-1:0] aa_idx;
	logic aa_re;
	word_t rd_word;
	logic raise_int;
	logic int_enable;

	// --------------------------------------------------
	// request capture
	// --------------------------------------------------
	// write strobe takes the slot when both fire
	always_comb begin
		if (bk_ls_wstart) begin
			ls_in = '{rd: 1'b0, addr: bk_ls_waddr, data: bk_ls_wdata, strb: bk_ls_wstrb};
		end else begin
			ls_in = '{rd: 1'b1, addr: bk_ls_raddr, data: '0, strb: '0};
		end
	end
	assign ls_push = (bk_ls_wstart || bk_ls_rstart) && !ls_full;

	// stream beats, held off while the queue is full
	assign ss_in = '{data: bk_ss_data, tag: bk_ss_user};
	assign bk_ss_ready = !ss_full;
	assign ss_push = bk_ss_valid && bk_ss_ready;

	req_fifo #(.payload_t(ls_entry_t), .depth(fifo_depth)) ls_fifo (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
		.push(ls_push), .push_data(ls_in), .full(ls_full),
		.pop(ls_pop), .pop_data(ls_head), .not_empty(ls_avail)
	);

	req_fifo #(.payload_t(ss_beat_t), .depth(fifo_depth)) ss_fifo (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
		.push(ss_push), .push_data(ss_in), .full(ss_full),
		.pop(ss_pop), .pop_data(ss_head), .not_empty(ss_avail)
	);

	ss_pair_collector u_collector (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
		.beat(ss_head), .beat_avail(ss_avail), .beat_pop(ss_pop),
		.pair_valid(pair_valid), .pair_strb(pair_strb), .pair_addr(pair_addr),
		.pair_data(pair_data), .pair_take(pair_take)
	);

	mbox_regs u_regs (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
		.mb_we(mb_we), .mb_idx(mb_idx), .wr_strb(wr_strb), .wr_data(wr_data),
		.aa_we(aa_we), .aa_idx(aa_idx), .mb_re_idx(mb_re_idx), .aa_re(aa_re),
		.rd_word(rd_word), .raise_int(raise_int), .int_enable(int_enable),
		.axi_interrupt(axi_interrupt)
	);

	mbox_dispatch_fsm u_dispatch (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
		.ls_entry(ls_head), .ls_avail(ls_avail), .ls_pop(ls_pop),
		.pair_valid(pair_valid), .pair_strb(pair_strb), .pair_addr(pair_addr),
		.pair_data(pair_data), .pair_take(pair_take),
		.mb_we(mb_we), .mb_idx(mb_idx), .wr_strb(wr_strb), .wr_data(wr_data),
		.aa_we(aa_we), .aa_idx(aa_idx), .mb_re_idx(mb_re_idx), .aa_re(aa_re),
		.rd_word(rd_word), .raise_int(raise_int), .int_enable(int_enable),
		.bk_ls_rdata(bk_ls_rdata), .bk_ls_rdone(bk_ls_rdone),
		.bk_sm_start(bk_sm_start), .bk_sm_data(bk_sm_data), .bk_sm_user(bk_sm_user)
	);

endmodule

`default_nettype wire

// ==== src/mbox_dispatch_fsm.sv ====
/*
 * mailbox dispatcher
 * round-robin service of local requests and remote pairs, one at a time
 */
`timescale 1ns/100ps
`default_nettype none

module mbox_dispatch_fsm (
	input  logic axi_aclk,
	input  logic axi_aresetn,
	// local queue head
	input  mbox_link_pkg::ls_entry_t ls_entry,
	input  logic ls_avail,
	output logic ls_pop,
	// remote pair
	input  logic pair_valid,
	input  mbox_link_pkg::strb_t pair_strb,
	input  logic [mbox_link_pkg::remote_addr_w-1:0] pair_addr,
	input  mbox_link_pkg::word_t pair_data,
	output logic pair_take,
	// register file
	output logic mb_we,
	output logic [mbox_map_pkg::mb_index_w-1:0] mb_idx,
	output mbox_link_pkg::strb_t wr_strb,
	output mbox_link_pkg::word_t wr_data,
	output logic aa_we,
	output logic [mbox_map_pkg::aa_index_w-1:0] aa_idx,
	output logic [mbox_map_pkg::mb_index_w-1:0] mb_re_idx,
	output logic aa_re,
	input  mbox_link_pkg::word_t rd_word,
	output logic raise_int,
	input  logic int_enable,
	// backend outputs
	output mbox_link_pkg::word_t bk_ls_rdata,
	output logic bk_ls_rdone,
	output logic bk_sm_start,
	output mbox_link_pkg::word_t bk_sm_data,
	output mbox_link_pkg::tag_t bk_sm_user
);
	import mbox_map_pkg::*;
	import mbox_link_pkg::*;

	disp_state_t state;
	disp_state_t state_nxt;
	// source in service, 1 for the stream side
	logic cur_ss;
	logic last_ss;
	// mirror header already sent
	logic sent_hdr;
	logic serve_done;

	logic cur_rd;
	logic [remote_addr_w-1:0] cur_addr;
	strb_t cur_strb;
	word_t cur_data;

	logic in_mb;
	logic in_aa;
	logic in_blk;
	logic op_read;
	logic op_unsupp;
	logic op_mb_wr;
	logic op_aa_wr;
	logic op_mirror;
	logic op_remote;

	// --------------------------------------------------
	// request in service
	// --------------------------------------------------
	// both heads stay put until popped
	always_comb begin
		if (cur_ss) begin
			cur_rd = 1'b0;
			cur_addr = pair_addr;
			cur_strb = pair_strb;
			cur_data = pair_data;
		end else begin
			cur_rd = ls_entry.rd;
			cur_addr = remote_addr_w'(ls_entry.addr);
			cur_strb = ls_entry.strb;
			cur_data = ls_entry.data;
		end
	end

	// address decode
	assign in_mb = (cur_addr >= remote_addr_w'(mb_low)) && (cur_addr <= remote_addr_w'(mb_high));
	assign in_aa = (cur_addr >= remote_addr_w'(aa_low)) && (cur_addr <= remote_addr_w'(aa_high));
	assign in_blk = (cur_addr >= remote_addr_w'(mb_low))
		&& (cur_addr <= remote_addr_w'(block_high));

	// reads outside the block fall through with no reply
	assign op_read = !cur_ss && cur_rd && in_blk;
	assign op_unsupp = op_read && !in_mb && !in_aa;
	assign op_mb_wr = !cur_rd && in_mb;
	assign op_aa_wr = !cur_ss && !cur_rd && in_aa;
	assign op_mirror = !cur_ss && op_mb_wr;
	assign op_remote = cur_ss && op_mb_wr;

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			st_wait: begin
				if (ls_avail || pair_valid) begin
					state_nxt = st_decide;
				end
			end
			st_decide: begin
				if (op_read || op_mb_wr || op_aa_wr) begin
					state_nxt = st_move;
				end else begin
					state_nxt = st_wait;
				end
			end
			st_move: begin
				if (op_read || op_mirror) begin
					state_nxt = st_send;
				end else if (op_remote) begin
					state_nxt = st_int;
				end else begin
					state_nxt = st_wait;
				end
			end
			// mirror stays for header and data beat
			st_send: begin
				if (!(op_mirror && !sent_hdr)) begin
					state_nxt = st_wait;
				end
			end
			st_int: state_nxt = st_wait;
			default: state_nxt = st_wait;
		endcase
	end

	assign serve_done = (state != st_wait) && (state_nxt == st_wait);
	assign ls_pop = serve_done && !cur_ss;
	assign pair_take = serve_done && cur_ss;

	always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
		if (!axi_aresetn) begin
			state <= st_wait;
			cur_ss <= 1'b0;
			// local side first after reset
			last_ss <= 1'b1;
			sent_hdr <= 1'b0;
		end else begin
			state <= state_nxt;
			// round robin, the other side wins a tie
			if (state == st_wait && state_nxt == st_decide) begin
				cur_ss <= pair_valid && (!ls_avail || !last_ss);
			end
			if (serve_done) begin
				last_ss <= cur_ss;
			end
			if (state == st_send && op_mirror) begin
				sent_hdr <= !sent_hdr;
			end
		end
	end

	// read reply held until the next read
	always_ff @(posedge axi_aclk) begin
		if (state == st_move && op_read) begin
			bk_ls_rdata <= op_unsupp ? unsupp_value : rd_word;
		end
	end

	// --------------------------------------------------
	// register strobes and backend beats
	// --------------------------------------------------
	assign mb_we = (state == st_move) && op_mb_wr;
	assign aa_we = (state == st_move) && op_aa_wr;
	assign mb_idx = cur_addr[mb_index_w-1:0];
	assign mb_re_idx = cur_addr[mb_index_w-1:0];
	assign aa_idx = cur_addr[aa_index_w-1:0];
	assign aa_re = in_aa;
	assign wr_strb = cur_strb;
	assign wr_data = cur_data;
	assign raise_int = (state == st_int) && int_enable;

	assign bk_ls_rdone = (state == st_send) && op_read;
	assign bk_sm_start = (state == st_send) && op_mirror;
	// header is strobe over the zero-padded local address
	assign bk_sm_data = sent_hdr ? cur_data : {cur_strb, remote_addr_w'(ls_entry.addr)};
	assign bk_sm_user = bk_sm_start ? tag_write_pair : '0;

endmodule

`default_nettype wire

// ==== src/mbox_regs.sv ====
/*
 * mailbox register file
 * eight byte-strobed words, interrupt enable and RW1C status, interrupt pulse
 */
`timescale 1ns/100ps
`default_nettype none

module mbox_regs (
	input  logic axi_aclk,
	input  logic axi_aresetn,
	// write side
	input  logic mb_we,
	input  logic [mbox_map_pkg::mb_index_w-1:0] mb_idx,
	input  mbox_link_pkg::strb_t wr_strb,
	input  mbox_link_pkg::word_t wr_data,
	input  logic aa_we,
	input  logic [mbox_map_pkg::aa_index_w-1:0] aa_idx,
	// read side
	input  logic [mbox_map_pkg::mb_index_w-1:0] mb_re_idx,
	input  logic aa_re,
	output mbox_link_pkg::word_t rd_word,
	// interrupt
	input  logic raise_int,
	output logic int_enable,
	output logic axi_interrupt
);
	import mbox_map_pkg::*;
	import mbox_link_pkg::*;

	word_t mb_mem [mb_count];
	logic int_status;
	logic ctl_wr;
	logic fire;

	// control regs only listen to byte lane 0
	assign ctl_wr = aa_we && wr_strb[0];
	assign fire = raise_int && int_enable;

	// --------------------------------------------------
	// mailbox words
	// --------------------------------------------------
	always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
		if (!axi_aresetn) begin
			for (int i = 0; i < mb_count; i++) begin
				mb_mem[i] <= '0;
			end
		end else if (mb_we) begin
			// byte lanes under strobe
			for (int b = 0; b < strb_w; b++) begin
				if (wr_strb[b]) begin
					mb_mem[mb_idx][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
	end

	// --------------------------------------------------
	// enable, status, interrupt pulse
	// --------------------------------------------------
	always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
		if (!axi_aresetn) begin
			int_enable <= 1'b0;
			int_status <= 1'b0;
			axi_interrupt <= 1'b0;
		end else begin
			// single cycle, raise_int is a strobe
			axi_interrupt <= fire;
			if (ctl_wr && aa_idx == aa_enable_off) begin
				int_enable <= wr_data[0];
			end
			// set wins over clear
			if (fire) begin
				int_status <= 1'b1;
			end else if (ctl_wr && aa_idx == aa_status_off && wr_data[0]) begin
				int_status <= 1'b0;
			end
		end
	end

	// read mux, upper control bits are zero
	always_comb begin
		rd_word = '0;
		if (aa_re) begin
			rd_word[0] = (aa_idx == aa_enable_off) ? int_enable : int_status;
		end else begin
			rd_word = mb_mem[mb_re_idx];
		end
	end

endmodule

`default_nettype wire

// ==== src/ss_pair_collector.sv ====
/*
 * stream pair collector
 * joins header and data beats tagged write pair into one remote write
 */
`timescale 1ns/100ps
`default_nettype none

module ss_pair_collector (
	input  logic axi_aclk,
	input  logic axi_aresetn,
	input  mbox_link_pkg::ss_beat_t beat,
	input  logic beat_avail,
	output logic beat_pop,
	output logic pair_valid,
	output mbox_link_pkg::strb_t pair_strb,
	output logic [mbox_link_pkg::remote_addr_w-1:0] pair_addr,
	output mbox_link_pkg::word_t pair_data,
	input  logic pair_take
);
	import mbox_link_pkg::*;

	// header beat already held
	logic have_hdr;
	logic is_pair_beat;

	assign is_pair_beat = (beat.tag == tag_write_pair);
	// stall the queue while a finished pair waits
	assign beat_pop = beat_avail && !pair_valid;

	always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
		if (!axi_aresetn) begin
			have_hdr <= 1'b0;
			pair_valid <= 1'b0;
		end else begin
			if (pair_take) begin
				pair_valid <= 1'b0;
			end
			// other tags just fall out of the queue
			if (beat_pop && is_pair_beat) begin
				if (!have_hdr) begin
					have_hdr <= 1'b1;
				end else begin
					have_hdr <= 1'b0;
					pair_valid <= 1'b1;
				end
			end
		end
	end

	// header is strb in the top nibble, address below
	always_ff @(posedge axi_aclk) begin
		if (beat_pop && is_pair_beat) begin
			if (!have_hdr) begin
				pair_strb <= beat.data[data_w-1 -: strb_w];
				pair_addr <= beat.data[remote_addr_w-1:0];
			end else begin
				pair_data <= beat.data;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/req_fifo.sv ====
/*
 * request queue
 * small synchronous FIFO, payload type set per instance
 */
`timescale 1ns/100ps
`default_nettype none

module req_fifo #(
	parameter type payload_t = logic,
	parameter int depth = 8
) (
	input  logic axi_aclk,
	input  logic axi_aresetn,
	input  logic push,
	input  payload_t push_data,
	output logic full,
	input  logic pop,
	output payload_t pop_data,
	output logic not_empty
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	payload_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic do_push;
	logic do_pop;

	// push dropped when full, pop ignored when empty
	assign do_push = push && !full;
	assign do_pop = pop && not_empty;

	assign full = (count == cnt_w'(depth));
	assign not_empty = (count != '0);
	// head is always presented
	assign pop_data = mem[rd_ptr];

	// storage
	always_ff @(posedge axi_aclk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// pointers and fill level
	always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
		if (!axi_aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop keeps the level
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/mbox_link_pkg.sv ====
/*
 * mailbox link definitions
 * bus widths, stream tags, queue entry layouts and dispatcher states
 */
`default_nettype none

package mbox_link_pkg;

	// --------------------------------------------------
	// bus widths
	// --------------------------------------------------
	localparam int data_w = 32;
	localparam int strb_w = 4;
	// remote address field inside a pair header
	localparam int remote_addr_w = 28;

	typedef logic [data_w-1:0] word_t;
	typedef logic [strb_w-1:0] strb_t;

	// stream user tag
	typedef logic [1:0] tag_t;
	// two beats, header then data
	localparam tag_t tag_write_pair = 2'b01;

	// --------------------------------------------------
	// queue entries
	// --------------------------------------------------
	// local request, data/strb zero for reads
	typedef struct packed {
		logic rd;
		mbox_map_pkg::local_addr_t addr;
		word_t data;
		strb_t strb;
	} ls_entry_t;

	// one stream beat as received
	typedef struct packed {
		word_t data;
		tag_t tag;
	} ss_beat_t;

	localparam int fifo_depth = 8;

	// dispatcher states
	typedef enum logic [2:0] {st_wait, st_decide, st_move, st_send, st_int} disp_state_t;

endpackage

`default_nettype wire

// ==== src/mbox_map_pkg.sv ====
/*
 * mailbox register map
 * address windows, register counts and control field positions
 */
`default_nettype none

package mbox_map_pkg;

	// local AXI-Lite register address, word granular
	typedef logic [14:0] local_addr_t;

	// --------------------------------------------------
	// address windows
	// --------------------------------------------------
	// mailbox words
	localparam local_addr_t mb_low = 15'h2000;
	localparam local_addr_t mb_high = 15'h201F;
	// interrupt enable / status
	localparam local_addr_t aa_low = 15'h2100;
	localparam local_addr_t aa_high = 15'h2107;
	// anything up to here is ours, reads get all ones
	localparam local_addr_t block_high = 15'h2FFF;

	// --------------------------------------------------
	// register counts and fields
	// --------------------------------------------------
	localparam int mb_count = 8;
	// mailbox index taken from the address low bits
	localparam int mb_index_w = 3;
	localparam int aa_index_w = 1;
	// control offsets, only bit 0 is live in each
	localparam logic [aa_index_w-1:0] aa_enable_off = 1'b0;
	localparam logic [aa_index_w-1:0] aa_status_off = 1'b1;

	// read value for holes in the block
	localparam logic [31:0] unsupp_value = 32'hFFFF_FFFF;

endpackage

`default_nettype wire
